/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_risc16_core
RTL_TOP   := risc16_core
FILELIST  := risc16_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "TEST FAIL" $(LOG)
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* risc16_core.f */
+incdir+source
+incdir+verif
source/risc16_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/hazard_ctrl.sv
source/risc16_core.sv
verif/tb_risc16_core.sv

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module decode_stage import risc16_pkg::*; (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic                        i_stall,
    input  wire instr_t                      i_instr,
    input  wire logic                        i_valid,
    output logic [`RISC16_REG_BITS-1:0]      o_rd_idx1,
    output logic [`RISC16_REG_BITS-1:0]      o_rd_idx2,
    input  wire logic [`RISC16_XLEN-1:0]     i_rd_data1,
    input  wire logic [`RISC16_XLEN-1:0]     i_rd_data2,
    input  wire mem_wb_t                     i_wb,
    output dec_exec_t                        o_dec
);

    opcode_t                     opcode;
    logic [`RISC16_REG_BITS-1:0] tgt;
    logic [`RISC16_XLEN-1:0]     imm;
    logic [`RISC16_XLEN-1:0]     simm_ext;
    logic [`RISC16_XLEN-1:0]     limm_ext;
    logic                        wb_hit1;
    logic                        wb_hit2;
    dec_exec_t                   r_dec;

    // ------------------------------------------------------------------------
    // Field split and immediates
    // ------------------------------------------------------------------------

    assign simm_ext = {
        {(`RISC16_XLEN - `RISC16_SIMM_BITS){i_instr.rri.simm[`RISC16_SIMM_BITS-1]}},
        i_instr.rri.simm
    };
    assign limm_ext = {i_instr.ri.limm, {`RISC16_LUI_SHIFT{1'b0}}};

    // Source and target indices per opcode, all zero for an empty slot
    always_comb begin
        opcode    = ADD;
        tgt       = '0;
        o_rd_idx1 = '0;
        o_rd_idx2 = '0;
        imm       = '0;
        if (i_valid) begin
            opcode = i_instr.rrr.opcode;
            case (i_instr.rrr.opcode)
                ADD, NAND: begin
                    tgt       = i_instr.rrr.reg_a;
                    o_rd_idx1 = i_instr.rrr.reg_b;
                    o_rd_idx2 = i_instr.rrr.reg_c;
                end
                ADDI, LW: begin
                    tgt       = i_instr.rri.reg_a;
                    o_rd_idx1 = i_instr.rri.reg_b;
                    imm       = simm_ext;
                end
                LUI: begin
                    tgt = i_instr.ri.reg_a;
                    imm = limm_ext;
                end
                // Base in reg_b, store data from reg_a
                SW: begin
                    o_rd_idx1 = i_instr.rri.reg_b;
                    o_rd_idx2 = i_instr.rri.reg_a;
                    imm       = simm_ext;
                end
                default: begin
                    tgt = '0;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Decode register
    // ------------------------------------------------------------------------

    // A held instruction misses the write that leaves writeback this cycle
    assign wb_hit1 = i_wb.valid && (i_wb.tgt != '0) && (i_wb.tgt == r_dec.src1);
    assign wb_hit2 = i_wb.valid && (i_wb.tgt != '0) && (i_wb.tgt == r_dec.src2);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_dec.valid  <= 1'b0;
            r_dec.opcode <= ADD;
            r_dec.tgt    <= '0;
            r_dec.src1   <= '0;
            r_dec.src2   <= '0;
        end else if (!i_stall) begin
            r_dec.valid  <= i_valid;
            r_dec.opcode <= opcode;
            r_dec.tgt    <= tgt;
            r_dec.src1   <= o_rd_idx1;
            r_dec.src2   <= o_rd_idx2;
        end

        if (i_stall) begin
            if (wb_hit1) begin
                r_dec.operand1 <= i_wb.result;
            end
            if (wb_hit2) begin
                r_dec.operand2 <= i_wb.result;
            end
        end else begin
            r_dec.operand1 <= i_rd_data1;
            r_dec.operand2 <= i_rd_data2;
            r_dec.imm      <= imm;
        end
    end

    assign o_dec = r_dec;

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module execute_stage import risc16_pkg::*; (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    input  wire logic                    i_stall,
    input  wire dec_exec_t               i_dec,
    input  wire fwd_sel_t                i_fwd_sel1,
    input  wire fwd_sel_t                i_fwd_sel2,
    input  wire logic [`RISC16_XLEN-1:0] i_exec_result,
    input  wire logic [`RISC16_XLEN-1:0] i_mem_result,
    input  wire logic [`RISC16_XLEN-1:0] i_wb_result,
    output exec_mem_t                    o_exec
);

    logic [`RISC16_XLEN-1:0] operand1;
    logic [`RISC16_XLEN-1:0] operand2;
    logic [`RISC16_XLEN-1:0] alu_in_b;
    logic [`RISC16_XLEN-1:0] alu_out;
    exec_mem_t               r_exec;

    function automatic logic [`RISC16_XLEN-1:0] fwd_mux(
        input fwd_sel_t                sel,
        input logic [`RISC16_XLEN-1:0] reg_val,
        input logic [`RISC16_XLEN-1:0] exec_val,
        input logic [`RISC16_XLEN-1:0] mem_val,
        input logic [`RISC16_XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EXEC: return exec_val;
            FWD_MEM:  return mem_val;
            FWD_WB:   return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Operands and ALU
    // ------------------------------------------------------------------------

    assign operand1 = fwd_mux(i_fwd_sel1, i_dec.operand1, i_exec_result, i_mem_result,
                              i_wb_result);
    assign operand2 = fwd_mux(i_fwd_sel2, i_dec.operand2, i_exec_result, i_mem_result,
                              i_wb_result);

    // Register form uses operand 2, everything else the immediate
    always_comb begin
        case (i_dec.opcode)
            ADD, NAND: alu_in_b = operand2;
            default:   alu_in_b = i_dec.imm;
        endcase
    end

    assign alu_out = (i_dec.opcode == NAND) ? ~(operand1 & alu_in_b) : operand1 + alu_in_b;

    // ------------------------------------------------------------------------
    // Execute register
    // ------------------------------------------------------------------------

    // Load-use stall puts a bubble here
    always_ff @(posedge i_clk) begin
        if (i_rst || i_stall) begin
            r_exec.valid  <= 1'b0;
            r_exec.opcode <= ADD;
            r_exec.tgt    <= '0;
        end else begin
            r_exec.valid  <= i_dec.valid;
            r_exec.opcode <= i_dec.opcode;
            r_exec.tgt    <= i_dec.tgt;
        end
        r_exec.alu_result <= alu_out;
        r_exec.store_data <= operand2;
    end

    assign o_exec = r_exec;

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module fetch_unit import risc16_pkg::*; (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_stall,
    input  wire instr_t             i_inst,
    output logic [`RISC16_XLEN-1:0] o_pc,
    output instr_t                  o_instr,
    output logic                    o_valid
);

    logic [`RISC16_XLEN-1:0] r_pc;
    instr_t                  r_instr;
    logic                    r_valid;

    // PC and valid bit, both frozen for a load-use stall
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_pc    <= '0;
            r_valid <= 1'b0;
        end else if (!i_stall) begin
            r_pc    <= r_pc + 1'b1;
            r_valid <= 1'b1;
        end
    end

    // Instruction word from the combinational memory read
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            r_instr <= i_inst;
        end
    end

    assign o_pc    = r_pc;
    assign o_instr = r_instr;
    assign o_valid = r_valid;

endmodule

`default_nettype wire

/* source/hazard_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module hazard_ctrl import risc16_pkg::*; (
    input  wire logic [`RISC16_REG_BITS-1:0] i_src1,
    input  wire logic [`RISC16_REG_BITS-1:0] i_src2,
    input  wire exec_mem_t                   i_exec,
    input  wire logic [`RISC16_REG_BITS-1:0] i_mem_tgt,
    input  wire logic [`RISC16_REG_BITS-1:0] i_wb_tgt,
    output logic                             o_stall,
    output fwd_sel_t                         o_fwd_sel1,
    output fwd_sel_t                         o_fwd_sel2
);

    logic [`RISC16_REG_BITS-1:0] exec_tgt;
    logic                        load_in_exec;

    // Youngest producer wins
    function automatic fwd_sel_t fwd_pick(
        input logic [`RISC16_REG_BITS-1:0] src,
        input logic [`RISC16_REG_BITS-1:0] ex_tgt,
        input logic [`RISC16_REG_BITS-1:0] mem_tgt,
        input logic [`RISC16_REG_BITS-1:0] wb_tgt
    );
        if (src == '0) begin
            return FWD_REG;
        end else if (src == ex_tgt) begin
            return FWD_EXEC;
        end else if (src == mem_tgt) begin
            return FWD_MEM;
        end else if (src == wb_tgt) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign exec_tgt = i_exec.valid ? i_exec.tgt : '0;

    // Load data is not ready until the memory stage
    assign load_in_exec = (i_exec.opcode == LW) && (exec_tgt != '0);
    assign o_stall      = load_in_exec && ((exec_tgt == i_src1) || (exec_tgt == i_src2));

    assign o_fwd_sel1 = fwd_pick(i_src1, exec_tgt, i_mem_tgt, i_wb_tgt);
    assign o_fwd_sel2 = fwd_pick(i_src2, exec_tgt, i_mem_tgt, i_wb_tgt);

endmodule

`default_nettype wire

/* source/mem_wb_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module mem_wb_stage import risc16_pkg::*; (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire exec_mem_t                   i_exec,
    input  wire logic [`RISC16_XLEN-1:0]     i_mem_rd_data,
    output logic [`RISC16_XLEN-1:0]          o_mem_addr,
    output logic [`RISC16_XLEN-1:0]          o_mem_wr_data,
    output logic                             o_mem_wr_en,
    output logic [`RISC16_XLEN-1:0]          o_mem_result,
    output logic                             o_rf_wr_en,
    output logic [`RISC16_REG_BITS-1:0]      o_rf_wr_idx,
    output mem_wb_t                          o_wb
);

    mem_wb_t r_mem;
    logic    r_mem_load;
    mem_wb_t r_wb;

    // Data memory request straight from the execute register
    assign o_mem_addr    = i_exec.alu_result;
    assign o_mem_wr_data = i_exec.store_data;
    assign o_mem_wr_en   = i_exec.valid && (i_exec.opcode == SW);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_mem.valid <= 1'b0;
            r_mem.tgt   <= '0;
            r_mem_load  <= 1'b0;
            r_wb.valid  <= 1'b0;
            r_wb.tgt    <= '0;
        end else begin
            r_mem.valid <= i_exec.valid;
            r_mem.tgt   <= i_exec.tgt;
            r_mem_load  <= i_exec.valid && (i_exec.opcode == LW);
            r_wb.valid  <= r_mem.valid;
            r_wb.tgt    <= r_mem.tgt;
        end
        r_mem.result <= i_exec.alu_result;
        r_wb.result  <= o_mem_result;
    end

    // Read data arrives one cycle after the address
    assign o_mem_result = r_mem_load ? i_mem_rd_data : r_mem.result;

    assign o_rf_wr_en  = r_mem.valid;
    assign o_rf_wr_idx = r_mem.tgt;
    assign o_wb        = r_wb;

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module register_file (
    input  wire logic                        i_clk,
    input  wire logic [`RISC16_REG_BITS-1:0] i_rd_idx1,
    input  wire logic [`RISC16_REG_BITS-1:0] i_rd_idx2,
    output logic [`RISC16_XLEN-1:0]          o_rd_data1,
    output logic [`RISC16_XLEN-1:0]          o_rd_data2,
    input  wire logic                        i_wr_en,
    input  wire logic [`RISC16_REG_BITS-1:0] i_wr_idx,
    input  wire logic [`RISC16_XLEN-1:0]     i_wr_data
);

    logic [`RISC16_XLEN-1:0] r_regs [`RISC16_NUM_REGS];

    // r0 is never written
    always_ff @(posedge i_clk) begin
        if (i_wr_en && (i_wr_idx != '0)) begin
            r_regs[i_wr_idx] <= i_wr_data;
        end
    end

    // Asynchronous reads, r0 forced to zero
    assign o_rd_data1 = (i_rd_idx1 == '0) ? '0 : r_regs[i_rd_idx1];
    assign o_rd_data2 = (i_rd_idx2 == '0) ? '0 : r_regs[i_rd_idx2];

endmodule

`default_nettype wire

/* source/risc16_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module risc16_core import risc16_pkg::*; (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    input  wire instr_t                  i_inst,
    output logic [`RISC16_XLEN-1:0]      o_pc,
    output logic [`RISC16_XLEN-1:0]      o_mem_addr,
    output logic [`RISC16_XLEN-1:0]      o_mem_wr_data,
    output logic                         o_mem_wr_en,
    input  wire logic [`RISC16_XLEN-1:0] i_mem_rd_data
);

    logic                        stall;
    instr_t                      f_instr;
    logic                        f_valid;
    logic [`RISC16_REG_BITS-1:0] rd_idx1;
    logic [`RISC16_REG_BITS-1:0] rd_idx2;
    logic [`RISC16_XLEN-1:0]     rd_data1;
    logic [`RISC16_XLEN-1:0]     rd_data2;
    dec_exec_t                   dec;
    exec_mem_t                   exec;
    mem_wb_t                     wb;
    logic [`RISC16_XLEN-1:0]     mem_result;
    logic                        rf_wr_en;
    logic [`RISC16_REG_BITS-1:0] rf_wr_idx;
    fwd_sel_t                    fwd_sel1;
    fwd_sel_t                    fwd_sel2;

    fetch_unit u_fetch (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (stall),
        .i_inst  (i_inst),
        .o_pc    (o_pc),
        .o_instr (f_instr),
        .o_valid (f_valid)
    );

    // Written from the memory stage
    register_file u_regfile (
        .i_clk      (i_clk),
        .i_rd_idx1  (rd_idx1),
        .i_rd_idx2  (rd_idx2),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2),
        .i_wr_en    (rf_wr_en),
        .i_wr_idx   (rf_wr_idx),
        .i_wr_data  (mem_result)
    );

    decode_stage u_decode (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_stall    (stall),
        .i_instr    (f_instr),
        .i_valid    (f_valid),
        .o_rd_idx1  (rd_idx1),
        .o_rd_idx2  (rd_idx2),
        .i_rd_data1 (rd_data1),
        .i_rd_data2 (rd_data2),
        .i_wb       (wb),
        .o_dec      (dec)
    );

    execute_stage u_execute (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (stall),
        .i_dec         (dec),
        .i_fwd_sel1    (fwd_sel1),
        .i_fwd_sel2    (fwd_sel2),
        .i_exec_result (exec.alu_result),
        .i_mem_result  (mem_result),
        .i_wb_result   (wb.result),
        .o_exec        (exec)
    );

    mem_wb_stage u_mem_wb (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_exec        (exec),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en),
        .o_mem_result  (mem_result),
        .o_rf_wr_en    (rf_wr_en),
        .o_rf_wr_idx   (rf_wr_idx),
        .o_wb          (wb)
    );

    hazard_ctrl u_hazard (
        .i_src1     (dec.src1),
        .i_src2     (dec.src2),
        .i_exec     (exec),
        .i_mem_tgt  (rf_wr_idx),
        .i_wb_tgt   (wb.tgt),
        .o_stall    (stall),
        .o_fwd_sel1 (fwd_sel1),
        .o_fwd_sel2 (fwd_sel2)
    );

endmodule

`default_nettype wire

/* source/risc16_params.svh */
`ifndef RISC16_PARAMS_SVH
`define RISC16_PARAMS_SVH

// Data path and address width
`define RISC16_XLEN       16

// Register file geometry
`define RISC16_REG_BITS   3
`define RISC16_NUM_REGS   8

// Instruction fields
`define RISC16_OP_BITS    3
`define RISC16_SIMM_BITS  7
`define RISC16_LIMM_BITS  10

// LUI puts its immediate in the upper ten bits
`define RISC16_LUI_SHIFT  6

`endif

/* source/risc16_pkg.sv */
`default_nettype none

`include "risc16_params.svh"

package risc16_pkg;

    // Opcodes 6 and 7 write nothing
    typedef enum logic [`RISC16_OP_BITS-1:0] {
        ADD  = 3'd0,
        ADDI = 3'd1,
        NAND = 3'd2,
        LUI  = 3'd3,
        SW   = 3'd4,
        LW   = 3'd5,
        RSV6 = 3'd6,
        RSV7 = 3'd7
    } opcode_t;

    // ------------------------------------------------------------------------
    // Instruction formats
    // ------------------------------------------------------------------------

    typedef struct packed {
        opcode_t                                        opcode;
        logic [`RISC16_REG_BITS-1:0]                    reg_a;
        logic [`RISC16_REG_BITS-1:0]                    reg_b;
        logic [`RISC16_SIMM_BITS-`RISC16_REG_BITS-1:0]  unused;
        logic [`RISC16_REG_BITS-1:0]                    reg_c;
    } rrr_t;

    typedef struct packed {
        opcode_t                      opcode;
        logic [`RISC16_REG_BITS-1:0]  reg_a;
        logic [`RISC16_REG_BITS-1:0]  reg_b;
        logic [`RISC16_SIMM_BITS-1:0] simm;
    } rri_t;

    typedef struct packed {
        opcode_t                      opcode;
        logic [`RISC16_REG_BITS-1:0]  reg_a;
        logic [`RISC16_LIMM_BITS-1:0] limm;
    } ri_t;

    // One instruction word, three views
    typedef union packed {
        rrr_t rrr;
        rri_t rri;
        ri_t  ri;
    } instr_t;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXEC,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // ------------------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic                        valid;
        opcode_t                     opcode;
        logic [`RISC16_REG_BITS-1:0] tgt;
        logic [`RISC16_REG_BITS-1:0] src1;
        logic [`RISC16_REG_BITS-1:0] src2;
        logic [`RISC16_XLEN-1:0]     operand1;
        logic [`RISC16_XLEN-1:0]     operand2;
        logic [`RISC16_XLEN-1:0]     imm;
    } dec_exec_t;

    typedef struct packed {
        logic                        valid;
        opcode_t                     opcode;
        logic [`RISC16_REG_BITS-1:0] tgt;
        logic [`RISC16_XLEN-1:0]     alu_result;
        logic [`RISC16_XLEN-1:0]     store_data;
    } exec_mem_t;

    typedef struct packed {
        logic                        valid;
        logic [`RISC16_REG_BITS-1:0] tgt;
        logic [`RISC16_XLEN-1:0]     result;
    } mem_wb_t;

endpackage

`default_nettype wire

/* verif/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

logic [31:0] lcg_state = 32'h1ae3_e04f;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_range(input int n);
    return int'((lcg_next() >> 8) % n);
endfunction

// ----------------------------------------------------------------------------
// Instruction encoders
// ----------------------------------------------------------------------------

function automatic logic [15:0] enc_rrr(input logic [2:0] op, input int a, input int b,
                                        input int c);
    return {op, a[2:0], b[2:0], 4'b0000, c[2:0]};
endfunction

function automatic logic [15:0] enc_rri(input logic [2:0] op, input int a, input int b,
                                        input int simm);
    return {op, a[2:0], b[2:0], simm[6:0]};
endfunction

function automatic logic [15:0] enc_ri(input logic [2:0] op, input int a, input int limm);
    return {op, a[2:0], limm[9:0]};
endfunction

// Mode 0 mixed, mode 1 ALU only, mode 2 load-use heavy
function automatic void build_program(input int mode);
    int sel;
    int ra;
    prog.delete();
    // Every register gets a known value first
    for (int r = 1; r < 8; r++) begin
        prog.push_back(enc_ri(LUI, r, rand_range(1024)));
        prog.push_back(enc_rri(ADDI, r, r, rand_range(128)));
    end
    while (prog.size() < 14 + BODY_LEN) begin
        sel = (mode == 1) ? rand_range(4) : rand_range(6);
        ra  = rand_range(8);
        if (mode == 2 && rand_range(3) == 0 && prog.size() < 13 + BODY_LEN) begin
            prog.push_back(enc_rri(LW, ra, rand_range(8), rand_range(128)));
            prog.push_back(enc_rrr(ADD, rand_range(8), ra, rand_range(8)));
        end else begin
            case (sel)
                0: prog.push_back(enc_rrr(ADD, ra, rand_range(8), rand_range(8)));
                1: prog.push_back(enc_rri(ADDI, ra, rand_range(8), rand_range(128)));
                2: prog.push_back(enc_rrr(NAND, ra, rand_range(8), rand_range(8)));
                3: prog.push_back(enc_ri(LUI, ra, rand_range(1024)));
                4: prog.push_back(enc_rri(SW, ra, rand_range(8), rand_range(128)));
                default: prog.push_back(enc_rri(LW, ra, rand_range(8), rand_range(128)));
            endcase
        end
    end
    // Dump r7 first, then base 0x100 in r7 for r1 to r6
    prog.push_back(enc_rri(SW, 7, 0, 63));
    prog.push_back(enc_ri(LUI, 7, 4));
    for (int r = 1; r < 7; r++) begin
        prog.push_back(enc_rri(SW, r, 7, r - 1));
    end
    prog.push_back(enc_rri(SW, 7, 7, 6));
endfunction

function automatic bit reads_reg(input logic [15:0] w, input logic [2:0] r);
    case (w[15:13])
        ADD, NAND: return (w[9:7] == r) || (w[2:0] == r);
        ADDI, LW:  return w[9:7] == r;
        SW:        return (w[9:7] == r) || (w[12:10] == r);
        default:   return 1'b0;
    endcase
endfunction

// Instruction-level reference, one instruction at a time in program order
function automatic void run_model();
    logic [15:0] regs [8];
    logic [15:0] mem [logic [15:0]];
    logic [15:0] w;
    logic [15:0] simm;
    logic [15:0] addr;
    logic [15:0] res;
    logic [2:0]  a;
    logic [2:0]  b;
    logic [2:0]  c;
    bit          wr;
    exp_addr.delete();
    exp_data.delete();
    exp_stalls = 0;
    foreach (regs[i]) regs[i] = '0;
    for (int i = 0; i < prog.size(); i++) begin
        w    = prog[i];
        a    = w[12:10];
        b    = w[9:7];
        c    = w[2:0];
        simm = {{9{w[6]}}, w[6:0]};
        addr = regs[b] + simm;
        wr   = 1'b1;
        res  = '0;
        case (w[15:13])
            ADD:  res = regs[b] + regs[c];
            ADDI: res = regs[b] + simm;
            NAND: res = ~(regs[b] & regs[c]);
            LUI:  res = {w[9:0], 6'b000000};
            LW:   res = mem.exists(addr) ? mem[addr] : (addr ^ 16'h5a5a);
            SW: begin
                wr = 1'b0;
                mem[addr] = regs[a];
                exp_addr.push_back(addr);
                exp_data.push_back(regs[a]);
            end
            default: wr = 1'b0;
        endcase
        if (wr && a != 3'd0) begin
            regs[a] = res;
        end
        if (i + 1 < prog.size() && w[15:13] == LW && a != 3'd0 && reads_reg(prog[i + 1], a)) begin
            exp_stalls++;
        end
    end
endfunction

`endif

/* verif/tb_risc16_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "risc16_params.svh"

module tb_risc16_core import risc16_pkg::*; ();

    localparam int NUM_TESTS    = 8;
    localparam int BODY_LEN     = 40;
    // Prologue of 14 and tail of 9 around the random body
    localparam int PROG_LEN     = BODY_LEN + 23;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (2 * PROG_LEN + 30 + 8);
    localparam int DRAIN_CYCLES = 10;

    logic                    i_clk;
    logic                    i_rst;
    instr_t                  i_inst;
    logic [`RISC16_XLEN-1:0] o_pc;
    logic [`RISC16_XLEN-1:0] o_mem_addr;
    logic [`RISC16_XLEN-1:0] o_mem_wr_data;
    logic                    o_mem_wr_en;
    logic [`RISC16_XLEN-1:0] i_mem_rd_data;

    logic [15:0] prog [$];
    logic [15:0] dmem [logic [15:0]];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int          exp_stalls;
    int          obs_count;
    int          hold_count;
    int          test_errors;
    int          total_errors = 0;
    int          tests_passed = 0;
    int          cycle_count = 0;
    logic        running = 1'b0;
    logic [15:0] prev_pc;
    logic [15:0] s_addr;
    logic [15:0] s_wdata;
    logic        s_wr_en = 1'b0;
    string       test_name;

    `include "tb_program.svh"

    risc16_core u_dut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_inst        (i_inst),
        .o_pc          (o_pc),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en),
        .i_mem_rd_data (i_mem_rd_data)
    );

    initial i_clk = 1'b0;
    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %s never finished its stores",
                     cycle_count, test_name);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] fetch_word(input logic [15:0] pc);
        // Past the program the word is ADD r0 and acts as a NOP
        return (pc < prog.size()) ? prog[pc] : 16'h0000;
    endfunction

    function automatic logic [15:0] read_dmem(input logic [15:0] addr);
        if ($isunknown(addr)) begin
            return '0;
        end
        return dmem.exists(addr) ? dmem[addr] : (addr ^ 16'h5a5a);
    endfunction

    // ------------------------------------------------------------------------
    // Memories, driven just after the clock edge
    // ------------------------------------------------------------------------

    always @(posedge i_clk) begin
        #1;
        if (s_wr_en === 1'b1) begin
            dmem[s_addr] = s_wdata;
        end
        i_mem_rd_data = read_dmem(s_addr);
        i_inst        = fetch_word(o_pc);
    end

    task automatic check_store();
        assert (obs_count < exp_addr.size()) else begin
            $display("%s: extra store to address %h after all %0d expected stores",
                     test_name, o_mem_addr, exp_addr.size());
            test_errors++;
        end
        if (obs_count < exp_addr.size()) begin
            assert (o_mem_addr == exp_addr[obs_count]) else begin
                $display("FAIL %s store %0d addr: expected %h actual %h", test_name,
                         obs_count, exp_addr[obs_count], o_mem_addr);
                test_errors++;
            end
            assert (o_mem_wr_data == exp_data[obs_count]) else begin
                $display("FAIL %s store %0d data: expected %h actual %h", test_name,
                         obs_count, exp_data[obs_count], o_mem_wr_data);
                test_errors++;
            end
        end
        obs_count++;
    endtask

    // Outputs are settled mid-cycle
    always @(negedge i_clk) begin
        s_addr  = o_mem_addr;
        s_wdata = o_mem_wr_data;
        s_wr_en = o_mem_wr_en;
        if (running) begin
            if (o_pc == prev_pc) begin
                hold_count++;
            end else begin
                assert (o_pc == prev_pc + 16'd1) else begin
                    $display("FAIL %s pc step: expected %h actual %h", test_name,
                             prev_pc + 16'd1, o_pc);
                    test_errors++;
                end
            end
            prev_pc = o_pc;
            if (o_mem_wr_en) begin
                check_store();
            end
        end
    end

    task automatic run_test(input int t);
        test_name = $sformatf("rand_prog_%0d", t);
        build_program(t % 3);
        run_model();
        test_errors = 0;
        obs_count   = 0;
        hold_count  = 0;
        @(posedge i_clk);
        #1;
        i_rst = 1'b1;
        dmem.delete();
        repeat (8) @(posedge i_clk);
        #1;
        assert (o_pc == '0) else begin
            $display("FAIL %s reset pc: expected 0000 actual %h", test_name, o_pc);
            test_errors++;
        end
        assert (o_mem_wr_en == 1'b0) else begin
            $display("FAIL %s reset store strobe: expected 0 actual %b", test_name,
                     o_mem_wr_en);
            test_errors++;
        end
        // First compare wraps to pc 0
        prev_pc = 16'hffff;
        running = 1'b1;
        i_rst   = 1'b0;
        while (obs_count < exp_addr.size()) begin
            @(posedge i_clk);
        end
        repeat (DRAIN_CYCLES) @(posedge i_clk);
        running = 1'b0;
        assert (obs_count == exp_addr.size()) else begin
            $display("%s: saw %0d stores but the program makes %0d", test_name,
                     obs_count, exp_addr.size());
            test_errors++;
        end
        assert (hold_count == exp_stalls) else begin
            $display("FAIL %s stall cycles: expected %0d actual %0d", test_name,
                     exp_stalls, hold_count);
            test_errors++;
        end
        $display("%s: %0d stores, %0d stalls, %s", test_name, obs_count, hold_count,
                 (test_errors == 0) ? "passed" : "failed");
        total_errors += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
        end
    endtask

    initial begin
        i_rst         = 1'b1;
        i_inst        = '0;
        i_mem_rd_data = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests: %0d run, %0d passed, %0d errors", NUM_TESTS, tests_passed,
                 total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
